/* source/uart_cmd_pkg.sv */
package uart_cmd_pkg;

  // Host command word, write flag on top.
  typedef struct packed {
    logic       write;
    logic [6:0] addr;
    logic [7:0] data;    // Don't care on reads.
  } uart_cmd_t;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cmd_op_e;

  // Read result, valid with rsp_vld only.
  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       timeout;
  } uart_rsp_t;

  typedef enum logic [2:0] {
    SEQ_IDLE     = 3'd0,
    SEQ_ADDR     = 3'd1,   // Address frame on the line.
    SEQ_GAP      = 3'd2,
    SEQ_DATA     = 3'd3,
    SEQ_WAIT_RSP = 3'd4
  } seq_state_e;

  // One byte of a UART frame.
  typedef logic [7:0] frame_t;

endpackage

/* source/uart_cmd_intake.sv */
module uart_cmd_intake (
  input  logic                    clk,
  input  logic                    rst_n,
  input  uart_cmd_pkg::uart_cmd_t cmd,
  input  logic                    cmd_vld,
  output logic                    cmd_rdy,
  output uart_cmd_pkg::uart_cmd_t pend_cmd,
  output uart_cmd_pkg::cmd_op_e   pend_op,
  output logic                    pend_vld,
  input  logic                    pend_take
);
  import uart_cmd_pkg::*;

  logic accept;

  assign cmd_rdy = !pend_vld;   // Ready exactly when empty.
  assign accept  = cmd_vld && cmd_rdy;

  // Opcode from the write flag.
  assign pend_op = pend_cmd.write ? OP_WRITE : OP_READ;

  // Fill and empty never coincide.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      pend_vld <= 1'b0;
    else if (accept)
      pend_vld <= 1'b1;
    else if (pend_take)
      pend_vld <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      pend_cmd <= cmd;
  end

endmodule

/* source/uart_frame_tx.sv */
module uart_frame_tx #(
  parameter int unsigned CLKS_PER_BIT = 434
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_cmd_pkg::frame_t tx_byte,
  input  logic                 tx_start,
  output logic                 tx_busy,
  output logic                 tx
);

  localparam int unsigned      CNT_W    = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [3:0]       IDX_STOP = 4'd10;

  logic [CNT_W-1:0] clk_cnt;   // Cycle within the bit.
  logic [3:0]       bit_idx;   // 0 is start, 10 is stop.
  logic [9:0]       shreg;     // Bits still to send.
  logic             bit_end;
  logic             load;

  assign bit_end = (clk_cnt == BIT_LAST);
  assign load    = tx_start && !tx_busy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_busy <= 1'b0;
      tx      <= 1'b1;
      clk_cnt <= '0;
      bit_idx <= '0;
    end
    else if (!tx_busy)
    begin
      if (tx_start)
      begin
        tx_busy <= 1'b1;
        tx      <= 1'b0;   // Start bit.
        clk_cnt <= '0;
        bit_idx <= '0;
      end
    end
    else if (!bit_end)
      clk_cnt <= clk_cnt + CNT_W'(1);
    else
    begin
      clk_cnt <= '0;
      if (bit_idx == IDX_STOP)
        tx_busy <= 1'b0;   // Stop bit done, line stays high.
      else
      begin
        tx      <= shreg[0];
        bit_idx <= bit_idx + 4'd1;
      end
    end
  end

  // Data LSB first, then even parity, then stop.
  always_ff @(posedge clk)
  begin
    if (load)
      shreg <= {1'b1, ^tx_byte, tx_byte};
    else if (tx_busy && bit_end)
      shreg <= {1'b1, shreg[9:1]};
  end

endmodule

/* source/uart_frame_rx.sv */
module uart_frame_rx #(
  parameter int unsigned CLKS_PER_BIT = 434
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx,
  output uart_cmd_pkg::frame_t rx_byte,
  output logic                 rx_perr,
  output logic                 rx_done,
  output logic                 rx_active
);

  typedef enum logic [1:0] {
    RX_IDLE  = 2'd0,
    RX_START = 2'd1,
    RX_BITS  = 2'd2,
    RX_STOP  = 2'd3
  } rx_state_e;

  localparam int unsigned      CNT_W     = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

  rx_state_e        state;
  logic             rx_meta;
  logic             rx_sync;
  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_idx;
  logic [8:0]       shreg;     // Data and parity, LSB arrives first.
  logic             sample;

  assign rx_active = (state != RX_IDLE);
  assign sample    = (clk_cnt == BIT_LAST);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= RX_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      rx_done <= 1'b0;
    end
    else
    begin
      rx_done <= 1'b0;
      clk_cnt <= clk_cnt + CNT_W'(1);
      case (state)
        RX_IDLE:
        begin
          clk_cnt <= '0;
          if (!rx_sync)
            state <= RX_START;
        end
        RX_START:
          if (clk_cnt == HALF_LAST)
          begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? RX_IDLE : RX_BITS;   // Glitch if high again.
          end
        RX_BITS:
          if (sample)
          begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 4'd1;
            if (bit_idx == 4'd8)
              state <= RX_STOP;
          end
        RX_STOP:
          if (sample)
          begin
            rx_done <= 1'b1;
            state   <= RX_IDLE;
          end
        default: state <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == RX_BITS && sample)
      shreg <= {rx_sync, shreg[8:1]};
    if (state == RX_STOP && sample)
    begin
      rx_byte <= shreg[7:0];
      rx_perr <= (^shreg) | !rx_sync;   // Odd ones count or missing stop.
    end
  end

endmodule

/* source/uart_cmd_sequencer.sv */
module uart_cmd_sequencer #(
  parameter int unsigned GAP_BITS      = 16,
  parameter int unsigned RSP_WAIT_BITS = 40,
  parameter int unsigned CLKS_PER_BIT  = 434
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  uart_cmd_pkg::uart_cmd_t pend_cmd,
  input  uart_cmd_pkg::cmd_op_e   pend_op,
  input  logic                    pend_vld,
  output logic                    pend_take,
  output uart_cmd_pkg::frame_t    tx_byte,
  output logic                    tx_start,
  input  logic                    tx_busy,
  input  uart_cmd_pkg::frame_t    rx_byte,
  input  logic                    rx_perr,
  input  logic                    rx_done,
  output uart_cmd_pkg::uart_rsp_t rsp,
  output logic                    rsp_vld
);
  import uart_cmd_pkg::*;

  localparam int unsigned GAP_CYC  = GAP_BITS * CLKS_PER_BIT;
  localparam int unsigned WAIT_CYC = RSP_WAIT_BITS * CLKS_PER_BIT;
  localparam int unsigned MAX_CYC  = (GAP_CYC > WAIT_CYC) ? GAP_CYC : WAIT_CYC;
  localparam int unsigned CNT_W    = $clog2(MAX_CYC + 1);

  seq_state_e       state;
  cmd_op_e          cur_op;
  frame_t           cur_data;
  logic [CNT_W-1:0] cnt;         // Shared by gap and reply timeout.
  logic             frame_done;
  logic             cnt_zero;

  assign pend_take  = (state == SEQ_IDLE) && pend_vld;
  // tx_busy is still low in the cycle of the start pulse.
  assign frame_done = !tx_start && !tx_busy;
  assign cnt_zero   = (cnt == '0);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= SEQ_IDLE;
      cur_op   <= OP_READ;
      cnt      <= '0;
      tx_start <= 1'b0;
      rsp_vld  <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      rsp_vld  <= 1'b0;
      case (state)
        SEQ_IDLE:
          if (pend_take)
          begin
            state    <= SEQ_ADDR;
            cur_op   <= pend_op;
            tx_start <= 1'b1;
          end
        SEQ_ADDR:
          if (frame_done)
          begin
            if (cur_op == OP_WRITE)
            begin
              state <= SEQ_GAP;
              cnt   <= CNT_W'(GAP_CYC - 1);
            end
            else
            begin
              state <= SEQ_WAIT_RSP;
              cnt   <= CNT_W'(WAIT_CYC - 1);
            end
          end
        SEQ_GAP:
          if (cnt_zero)
          begin
            state    <= SEQ_DATA;
            tx_start <= 1'b1;
          end
          else
            cnt <= cnt - CNT_W'(1);
        SEQ_DATA:
          if (frame_done)
            state <= SEQ_IDLE;
        SEQ_WAIT_RSP:
          if (rx_done || cnt_zero)
          begin
            state   <= SEQ_IDLE;
            rsp_vld <= 1'b1;
          end
          else
            cnt <= cnt - CNT_W'(1);
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (pend_take)
    begin
      tx_byte  <= {pend_op == OP_WRITE, pend_cmd.addr};   // Write flag in bit 7.
      cur_data <= pend_cmd.data;
    end
    else if (state == SEQ_GAP)
      tx_byte <= cur_data;

    if (state == SEQ_WAIT_RSP)
    begin
      if (rx_done)
      begin
        rsp.data       <= rx_byte;
        rsp.parity_err <= rx_perr;
        rsp.timeout    <= 1'b0;
      end
      else if (cnt_zero)
      begin
        rsp.data       <= 8'h00;
        rsp.parity_err <= 1'b0;
        rsp.timeout    <= 1'b1;
      end
    end
  end

endmodule

/* source/uart_cmd_top.sv */
module uart_cmd_top #(
  parameter int unsigned CLKS_PER_BIT  = 434,
  parameter int unsigned GAP_BITS      = 16,
  parameter int unsigned RSP_WAIT_BITS = 40
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  uart_cmd_pkg::uart_cmd_t cmd,
  input  logic                    cmd_vld,
  output logic                    cmd_rdy,
  input  logic                    rx,
  output logic                    tx,
  output uart_cmd_pkg::uart_rsp_t rsp,
  output logic                    rsp_vld
);
  import uart_cmd_pkg::*;

  uart_cmd_t pend_cmd;
  cmd_op_e   pend_op;
  logic      pend_vld;
  logic      pend_take;
  frame_t    tx_byte;
  logic      tx_start;
  logic      tx_busy;
  frame_t    rx_byte;
  logic      rx_perr;
  logic      rx_done;

  uart_cmd_intake u_intake (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .pend_cmd  (pend_cmd),
    .pend_op   (pend_op),
    .pend_vld  (pend_vld),
    .pend_take (pend_take)
  );

  uart_cmd_sequencer #(
    .GAP_BITS      (GAP_BITS),
    .RSP_WAIT_BITS (RSP_WAIT_BITS),
    .CLKS_PER_BIT  (CLKS_PER_BIT)
  ) u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .pend_cmd  (pend_cmd),
    .pend_op   (pend_op),
    .pend_vld  (pend_vld),
    .pend_take (pend_take),
    .tx_byte   (tx_byte),
    .tx_start  (tx_start),
    .tx_busy   (tx_busy),
    .rx_byte   (rx_byte),
    .rx_perr   (rx_perr),
    .rx_done   (rx_done),
    .rsp       (rsp),
    .rsp_vld   (rsp_vld)
  );

  uart_frame_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

  // Receiver runs free, the sequencer looks at it only while waiting.
  uart_frame_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_byte   (rx_byte),
    .rx_perr   (rx_perr),
    .rx_done   (rx_done),
    .rx_active ()
  );

endmodule

/* verif/uart_remote_model.sv */
module uart_remote_model #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic clk,
  input  logic rst_n,
  input  logic tx,
  output logic rx
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0] regs [128];   // Remote register file.
  logic [7:0] addr_byte;
  logic [7:0] data_byte;
  int         frame_errs;   // Bad parity or stop bits seen on tx.

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Data bits sampled near mid-bit, returns in the stop bit.
  task automatic get_frame(output logic [7:0] b);
    logic par;
    logic stp;
    do
      @(posedge clk);
    while (tx !== 1'b0);
    repeat (CLKS_PER_BIT / 2) @(posedge clk);
    for (int i = 0; i < 8; i++)
    begin
      repeat (CLKS_PER_BIT) @(posedge clk);
      b[i] = tx;
    end
    repeat (CLKS_PER_BIT) @(posedge clk);
    par = tx;
    repeat (CLKS_PER_BIT) @(posedge clk);
    stp = tx;
    if ($countones({par, b}) % 2 != 0)   // Even number of ones.
    begin
      frame_errs = frame_errs + 1;
      $display("error tx parity: got %h for byte %h", par, b);
    end
    if (stp !== 1'b1)
    begin
      frame_errs = frame_errs + 1;
      $display("error tx stop: got %h expected %h", stp, 1'b1);
    end
  endtask

  task automatic put_frame(input logic [7:0] b, input logic flip_par);
    logic [10:0] bits;
    bits = {1'b1, ^b ^ flip_par, b, 1'b0};
    for (int i = 0; i < 11; i++)
    begin
      @(negedge clk);
      rx = bits[i];
      repeat (CLKS_PER_BIT - 1) @(negedge clk);
    end
  endtask

  initial
  begin
    logic [31:0] state;
    rx         = 1'b1;
    frame_errs = 0;
    state      = 32'd79025;
    for (int i = 0; i < 128; i++)
    begin
      state   = xorshift32(state);
      regs[i] = state[7:0];
    end
    wait (rst_n === 1'b1);
    forever
    begin
      get_frame(addr_byte);
      if (addr_byte[7])
      begin
        get_frame(data_byte);
        regs[addr_byte[6:0]] = data_byte;
      end
      else if (addr_byte[6:0] != 7'h7f)   // 7f stays silent.
      begin
        repeat (4 * CLKS_PER_BIT) @(posedge clk);
        put_frame(regs[addr_byte[6:0]], addr_byte[6:0] == 7'h7e);
      end
    end
  end

endmodule

/* verif/uart_cmd_assert.sv */
module uart_cmd_assert (
  input logic                     clk,
  input logic                     rst_n,
  input uart_cmd_pkg::uart_cmd_t  cmd,
  input logic                     cmd_vld,
  input logic                     cmd_rdy,
  input logic                     tx,
  input logic                     tx_busy,
  input logic                     rsp_vld,
  input uart_cmd_pkg::seq_state_e state
);
  timeunit 1ns;
  timeprecision 100ps;
  import uart_cmd_pkg::*;

  a_rsp_pulse: assert property (@(posedge clk) disable iff (!rst_n) rsp_vld |=> !rsp_vld)
    else $error("rsp_vld high for more than one cycle");

  // Line idles high between transactions.
  a_tx_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state == SEQ_IDLE && !tx_busy) |-> tx)
    else $error("tx low while the sequencer is idle");

  a_cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_vld && !cmd_rdy) |=> $stable(cmd))
    else $error("cmd changed while waiting for cmd_rdy");

endmodule

bind uart_cmd_top uart_cmd_assert u_assert (
  .clk     (clk),
  .rst_n   (rst_n),
  .cmd     (cmd),
  .cmd_vld (cmd_vld),
  .cmd_rdy (cmd_rdy),
  .tx      (tx),
  .tx_busy (tx_busy),
  .rsp_vld (rsp_vld),
  .state   (u_seq.state)
);

/* verif/uart_cmd_tb.sv */
module uart_cmd_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import uart_cmd_pkg::*;

  localparam int CLKS_PER_BIT  = 8;
  localparam int GAP_BITS      = 16;
  localparam int RSP_WAIT_BITS = 40;
  localparam int N_ENTRIES     = 10;
  localparam int FRAME_CYC     = 11 * CLKS_PER_BIT;
  localparam int LIMIT = N_ENTRIES * (22 + GAP_BITS + RSP_WAIT_BITS + 11) * CLKS_PER_BIT + 200;

  // Columns: write, addr, data, exp_data, exp_perr, exp_tout, b2b.
  typedef struct packed {
    logic       write;
    logic [6:0] addr;
    logic [7:0] data;
    logic [7:0] exp_data;
    logic       exp_perr;
    logic       exp_tout;
    logic       b2b;   // Taken while the previous command is on the line.
  } entry_t;

  logic       clk;
  logic       rst_n;
  uart_cmd_t  cmd;
  logic       cmd_vld;
  logic       cmd_rdy;
  logic       rx;
  logic       tx;
  uart_rsp_t  rsp;
  logic       rsp_vld;
  entry_t     stim [N_ENTRIES];
  logic [7:0] preload [128];
  int         cycles;
  int         errors;
  int         n_reads;
  int         rsp_cnt = 0;

  uart_cmd_top #(
    .CLKS_PER_BIT  (CLKS_PER_BIT),
    .GAP_BITS      (GAP_BITS),
    .RSP_WAIT_BITS (RSP_WAIT_BITS)
  ) u_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd     (cmd),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .rx      (rx),
    .tx      (tx),
    .rsp     (rsp),
    .rsp_vld (rsp_vld)
  );

  uart_remote_model #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_remote (
    .clk   (clk),
    .rst_n (rst_n),
    .tx    (tx),
    .rx    (rx)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial
  begin
    cycles = 0;
    while (cycles < LIMIT)
    begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    $display("Timeout: the run did not finish within %0d cycles", LIMIT);
    $display("Errors found");
    $finish;
  end

  always @(negedge clk)
    if (rst_n === 1'b1 && rsp_vld === 1'b1)
      rsp_cnt <= rsp_cnt + 1;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic count_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    errors = errors + 1;
    $display("error %s: got %h expected %h", name, got, exp);
  endtask

  task automatic count_failure(input string msg);
    errors = errors + 1;
    $display("%s", msg);
  endtask

  // Starts and ends on a falling edge.
  task automatic issue_cmd(input entry_t e, output int acc_cyc);
    while (!cmd_rdy)
      @(negedge clk);
    cmd     = '{e.write, e.addr, e.data};
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
    acc_cyc = cycles;
  endtask

  task automatic collect_rsp(input entry_t e);
    while (!rsp_vld)
      @(negedge clk);
    if (rsp.data !== e.exp_data)
      count_mismatch("rsp.data", 32'(rsp.data), 32'(e.exp_data));
    if (rsp.parity_err !== e.exp_perr)
      count_mismatch("rsp.parity_err", 32'(rsp.parity_err), 32'(e.exp_perr));
    if (rsp.timeout !== e.exp_tout)
      count_mismatch("rsp.timeout", 32'(rsp.timeout), 32'(e.exp_tout));
    @(negedge clk);
  endtask

  initial
  begin
    logic [31:0] seed;
    int          acc;
    int          prev_acc;
    cmd      = '0;
    cmd_vld  = 1'b0;
    rst_n    = 1'b0;
    errors   = 0;
    n_reads  = 0;
    prev_acc = 0;
    seed     = 32'd79025;
    for (int i = 0; i < 128; i++)
    begin
      seed       = xorshift32(seed);
      preload[i] = seed[7:0];
    end
    stim[0] = '{1'b0, 7'h05, 8'h00, preload[7'h05], 1'b0, 1'b0, 1'b0};
    stim[1] = '{1'b0, 7'h40, 8'h00, preload[7'h40], 1'b0, 1'b0, 1'b0};
    stim[2] = '{1'b1, 7'h12, 8'ha5, 8'h00, 1'b0, 1'b0, 1'b0};
    stim[3] = '{1'b0, 7'h12, 8'h00, 8'ha5, 1'b0, 1'b0, 1'b1};
    stim[4] = '{1'b1, 7'h7e, 8'h3c, 8'h00, 1'b0, 1'b0, 1'b0};
    stim[5] = '{1'b0, 7'h7e, 8'h00, 8'h3c, 1'b1, 1'b0, 1'b1};   // Bad parity reply.
    stim[6] = '{1'b0, 7'h7f, 8'h00, 8'h00, 1'b0, 1'b1, 1'b0};   // No reply.
    stim[7] = '{1'b0, 7'h05, 8'h00, preload[7'h05], 1'b0, 1'b0, 1'b0};
    stim[8] = '{1'b1, 7'h00, 8'hff, 8'h00, 1'b0, 1'b0, 1'b0};
    stim[9] = '{1'b0, 7'h00, 8'h00, 8'hff, 1'b0, 1'b0, 1'b1};
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (cmd_rdy !== 1'b1)
      count_mismatch("cmd_rdy", 32'(cmd_rdy), 32'h1);
    if (rsp_vld !== 1'b0)
      count_mismatch("rsp_vld", 32'(rsp_vld), 32'h0);
    if (tx !== 1'b1)
      count_mismatch("tx", 32'(tx), 32'h1);
    for (int i = 0; i < N_ENTRIES; i++)
    begin
      issue_cmd(stim[i], acc);
      if (stim[i].b2b && (acc - prev_acc >= FRAME_CYC))
        count_failure($sformatf("Entry %0d was not taken while the line was busy", i));
      prev_acc = acc;
      if (!stim[i].write)
      begin
        n_reads = n_reads + 1;
        collect_rsp(stim[i]);
      end
    end
    repeat (2) @(negedge clk);
    if (rsp_cnt != n_reads)
      count_mismatch("rsp_vld pulses", rsp_cnt, n_reads);
    errors = errors + u_remote.frame_errs;   // Frame format faults seen on tx.
    $display("Run complete, error count %0d", errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

/* flist.f */
source/uart_cmd_pkg.sv
source/uart_cmd_intake.sv
source/uart_frame_tx.sv
source/uart_frame_rx.sv
source/uart_cmd_sequencer.sv
source/uart_cmd_top.sv
verif/uart_remote_model.sv
verif/uart_cmd_assert.sv
verif/uart_cmd_tb.sv

/* Makefile */
LOG := sim.log

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module uart_cmd_tb -f flist.f -Mdir obj_dir
	./obj_dir/Vuart_cmd_tb | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
